// ==== rtl/engine_pkg.sv ====
// Shared widths, FIFO depths and thresholds for the engine pipeline RTL and its testbench
package engine_pkg;

    // ----------------------------------------------------------------------
    // Packet payload
    // ----------------------------------------------------------------------
    localparam int PAYLOAD_W = 32;

    // ----------------------------------------------------------------------
    // Packet FIFO sizing
    // ----------------------------------------------------------------------
    localparam int FIFO_DEPTH = 16;
    localparam int ADDR_W     = $clog2(FIFO_DEPTH);
    // Occupancy count runs from 0 to FIFO_DEPTH inclusive
    localparam int COUNT_W    = $clog2(FIFO_DEPTH + 1);

    // Register stages between the input FIFO and the output FIFO
    localparam int PIPELINE_STAGES = 2;

    // Output FIFO threshold that stops input pops.
    // Up to PIPELINE_STAGES + 3 packets are still on their way when it trips,
    // so keep it at or below FIFO_DEPTH - PIPELINE_STAGES - 3
    localparam int PROG_THRESH = 8;

endpackage : engine_pkg

// ==== rtl/fifo_port_if.sv ====
// Read side and status flags of one packet FIFO, shared between the FIFO and its lane
`timescale 1ns/100ps

interface fifo_port_if;
    import engine_pkg::*;

    // Pop request from the lane
    logic                 rd_en;

    // Registered read data and FIFO status
    logic [PAYLOAD_W-1:0] dout;
    logic                 valid;
    logic                 empty;
    logic                 full;
    logic                 prog_full;

    modport fifo_side (
        input  rd_en,
        output dout, valid, empty, full, prog_full
    );

    modport lane_side (
        output rd_en,
        input  dout, valid, empty, full, prog_full
    );

endinterface : fifo_port_if

// ==== rtl/packet_fifo.sv ====
// Synchronous packet FIFO with a registered read port, used for both FIFOs of a lane
`timescale 1ns/100ps

module packet_fifo (
    input  logic                            ap_clk,
    input  logic                            reset,
    input  logic                            wr_en,
    input  logic [engine_pkg::PAYLOAD_W-1:0] din,
    fifo_port_if.fifo_side                  port
);
    import engine_pkg::*;

    // ----------------------------------------------------------------------
    // Storage and pointers
    // ----------------------------------------------------------------------
    logic [PAYLOAD_W-1:0] mem [FIFO_DEPTH];
    logic [ADDR_W-1:0]    wr_ptr;
    logic [ADDR_W-1:0]    rd_ptr;
    logic [COUNT_W-1:0]   count;

    logic do_write;
    logic do_read;

    // Writes into a full FIFO are dropped
    assign do_write = wr_en & ~port.full;
    assign do_read  = port.rd_en & ~port.empty;

    // ----------------------------------------------------------------------
    // Status flags from the occupancy count
    // ----------------------------------------------------------------------
    assign port.empty     = (count == '0);
    assign port.full      = (count == COUNT_W'(FIFO_DEPTH));
    assign port.prog_full = (count >= COUNT_W'(PROG_THRESH));

    // Pointers, count and read valid
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            port.valid <= 1'b0;
        end else begin
            port.valid <= do_read;

            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Buffer write
    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    // Head goes out one cycle after the pop
    always_ff @(posedge ap_clk) begin
        if (do_read) begin
            port.dout <= mem[rd_ptr];
        end
    end

    // ----------------------------------------------------------------------
    // Handshake checks
    // ----------------------------------------------------------------------

    // Upstream must honour full, otherwise a packet is lost
    assert property (@(posedge ap_clk) disable iff (reset)
        wr_en |-> !port.full)
    else $error("packet_fifo: write while full, packet dropped");

    // The lane gates its pops with empty
    assert property (@(posedge ap_clk) disable iff (reset)
        port.rd_en |-> !port.empty)
    else $error("packet_fifo: read while empty");

endmodule : packet_fifo

// ==== rtl/hyper_pipeline.sv ====
// Fixed-depth register pipeline that delays a valid-qualified packet between the lane FIFOs
`timescale 1ns/100ps

module hyper_pipeline (
    input  logic                             ap_clk,
    input  logic                             reset,
    input  logic                             in_valid,
    input  logic [engine_pkg::PAYLOAD_W-1:0] in_payload,
    output logic                             out_valid,
    output logic [engine_pkg::PAYLOAD_W-1:0] out_payload
);
    import engine_pkg::*;

    logic                 valid_q   [PIPELINE_STAGES];
    logic [PAYLOAD_W-1:0] payload_q [PIPELINE_STAGES];

    // Valid chain, one packet may sit in every stage
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            for (int i = 0; i < PIPELINE_STAGES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < PIPELINE_STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Payload chain
    always_ff @(posedge ap_clk) begin
        payload_q[0] <= in_payload;
        for (int i = 1; i < PIPELINE_STAGES; i++) begin
            payload_q[i] <= payload_q[i-1];
        end
    end

    assign out_valid   = valid_q[PIPELINE_STAGES-1];
    assign out_payload = payload_q[PIPELINE_STAGES-1];

endmodule : hyper_pipeline

// ==== rtl/engine_lane.sv ====
// One packet lane: input register, input FIFO, pipeline, output FIFO and output register
`timescale 1ns/100ps

module engine_lane (
    input  logic                             ap_clk,
    input  logic                             reset,
    input  logic                             response_valid,
    input  logic [engine_pkg::PAYLOAD_W-1:0] response_payload,
    input  logic                             response_pop_en,
    output logic                             response_full,
    output logic                             response_prog_full,
    input  logic                             request_pop_en,
    output logic                             request_valid,
    output logic [engine_pkg::PAYLOAD_W-1:0] request_payload,
    output logic                             lane_empty
);
    import engine_pkg::*;

    // ----------------------------------------------------------------------
    // Internal signals
    // ----------------------------------------------------------------------
    logic                 response_valid_q;
    logic [PAYLOAD_W-1:0] response_payload_q;
    logic                 response_pop_en_q;
    logic                 request_pop_en_q;

    logic                 pipe_valid;
    logic [PAYLOAD_W-1:0] pipe_payload;

    // Packets accepted at the input and not yet sent as requests
    logic [COUNT_W:0]     in_flight_q;

    fifo_port_if in_port ();
    fifo_port_if out_port ();

    // ----------------------------------------------------------------------
    // Input register
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            response_valid_q  <= 1'b0;
            response_pop_en_q <= 1'b0;
            request_pop_en_q  <= 1'b0;
        end else begin
            response_valid_q  <= response_valid;
            response_pop_en_q <= response_pop_en;
            request_pop_en_q  <= request_pop_en;
        end
    end

    always_ff @(posedge ap_clk) begin
        response_payload_q <= response_payload;
    end

    // ----------------------------------------------------------------------
    // Input FIFO and pop gating
    // ----------------------------------------------------------------------
    // Hold pops while the output FIFO is over its threshold
    assign in_port.rd_en = ~in_port.empty & response_pop_en_q & ~out_port.prog_full;

    packet_fifo in_fifo (
        .ap_clk (ap_clk),
        .reset  (reset),
        .wr_en  (response_valid_q),
        .din    (response_payload_q),
        .port   (in_port.fifo_side)
    );

    hyper_pipeline pipe_u (
        .ap_clk      (ap_clk),
        .reset       (reset),
        .in_valid    (in_port.valid),
        .in_payload  (in_port.dout),
        .out_valid   (pipe_valid),
        .out_payload (pipe_payload)
    );

    // ----------------------------------------------------------------------
    // Output FIFO
    // ----------------------------------------------------------------------
    assign out_port.rd_en = ~out_port.empty & request_pop_en_q;

    packet_fifo out_fifo (
        .ap_clk (ap_clk),
        .reset  (reset),
        .wr_en  (pipe_valid),
        .din    (pipe_payload),
        .port   (out_port.fifo_side)
    );

    // Output register and status back to the sender
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            request_valid      <= 1'b0;
            response_full      <= 1'b0;
            response_prog_full <= 1'b0;
        end else begin
            request_valid      <= out_port.valid;
            response_full      <= in_port.full;
            // Either FIFO over threshold means the lane is pushing back
            response_prog_full <= in_port.prog_full | out_port.prog_full;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_payload <= out_port.dout;
    end

    assign lane_empty = in_port.empty & out_port.empty;

    // ----------------------------------------------------------------------
    // Lane accounting
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset) begin
            in_flight_q <= '0;
        end else begin
            case ({response_valid_q, request_valid})
                2'b10: in_flight_q <= in_flight_q + 1'b1;
                2'b01: in_flight_q <= in_flight_q - 1'b1;
                default: in_flight_q <= in_flight_q;
            endcase
        end
    end

    // Every request must match an earlier input write
    assert property (@(posedge ap_clk) disable iff (reset)
        request_valid |-> (in_flight_q != '0))
    else $error("engine_lane: request without a preceding write");

endmodule : engine_lane

// ==== rtl/engine_pipeline.sv ====
// Top level of the engine pipeline shell with the engine lane, the memory lane and done
`timescale 1ns/100ps

module engine_pipeline (
    input  logic                             ap_clk,
    input  logic                             areset_template_engine,

    // Engine lane
    input  logic                             response_engine_valid,
    input  logic [engine_pkg::PAYLOAD_W-1:0] response_engine_payload,
    input  logic                             response_engine_pop_en,
    output logic                             response_engine_full,
    output logic                             response_engine_prog_full,
    input  logic                             request_engine_pop_en,
    output logic                             request_engine_valid,
    output logic [engine_pkg::PAYLOAD_W-1:0] request_engine_payload,

    // Memory lane
    input  logic                             response_memory_valid,
    input  logic [engine_pkg::PAYLOAD_W-1:0] response_memory_payload,
    input  logic                             response_memory_pop_en,
    output logic                             response_memory_full,
    output logic                             response_memory_prog_full,
    input  logic                             request_memory_pop_en,
    output logic                             request_memory_valid,
    output logic [engine_pkg::PAYLOAD_W-1:0] request_memory_payload,

    output logic                             done_out
);

    // ----------------------------------------------------------------------
    // Internal reset
    // ----------------------------------------------------------------------
    logic reset_q;

    logic engine_lane_empty;
    logic memory_lane_empty;
    logic lanes_empty_q;

    // One more flop on the reset input, it drives every block below
    always_ff @(posedge ap_clk) begin
        reset_q <= areset_template_engine;
    end

    // ----------------------------------------------------------------------
    // Lanes
    // ----------------------------------------------------------------------
    engine_lane engine_lane_u (
        .ap_clk             (ap_clk),
        .reset              (reset_q),
        .response_valid     (response_engine_valid),
        .response_payload   (response_engine_payload),
        .response_pop_en    (response_engine_pop_en),
        .response_full      (response_engine_full),
        .response_prog_full (response_engine_prog_full),
        .request_pop_en     (request_engine_pop_en),
        .request_valid      (request_engine_valid),
        .request_payload    (request_engine_payload),
        .lane_empty         (engine_lane_empty)
    );

    engine_lane memory_lane_u (
        .ap_clk             (ap_clk),
        .reset              (reset_q),
        .response_valid     (response_memory_valid),
        .response_payload   (response_memory_payload),
        .response_pop_en    (response_memory_pop_en),
        .response_full      (response_memory_full),
        .response_prog_full (response_memory_prog_full),
        .request_pop_en     (request_memory_pop_en),
        .request_valid      (request_memory_valid),
        .request_payload    (request_memory_payload),
        .lane_empty         (memory_lane_empty)
    );

    // ----------------------------------------------------------------------
    // Done flag
    // ----------------------------------------------------------------------
    // All four FIFOs empty, two cycles late
    always_ff @(posedge ap_clk) begin
        if (reset_q) begin
            lanes_empty_q <= 1'b0;
            done_out      <= 1'b0;
        end else begin
            lanes_empty_q <= engine_lane_empty & memory_lane_empty;
            done_out      <= lanes_empty_q;
        end
    end

endmodule : engine_pipeline

// ==== verif/tb_engine_pipeline.sv ====
// Directed testbench for the engine pipeline; compile with the RTL and run as the simulation top
`timescale 1ns/100ps

module tb_engine_pipeline;
    import engine_pkg::*;

    localparam int  CLK_PERIOD   = 4;
    localparam int  RESET_CYCLES = 4;
    localparam time MIN_DELAY    = 8 * CLK_PERIOD;
    localparam int  WAIT_LIMIT   = 2000;

    logic                 ap_clk = 1'b0;
    logic                 areset_template_engine;
    logic                 response_engine_valid;
    logic [PAYLOAD_W-1:0] response_engine_payload;
    logic                 response_engine_pop_en;
    logic                 response_engine_full;
    logic                 response_engine_prog_full;
    logic                 request_engine_pop_en;
    logic                 request_engine_valid;
    logic [PAYLOAD_W-1:0] request_engine_payload;
    logic                 response_memory_valid;
    logic [PAYLOAD_W-1:0] response_memory_payload;
    logic                 response_memory_pop_en;
    logic                 response_memory_full;
    logic                 response_memory_prog_full;
    logic                 request_memory_pop_en;
    logic                 request_memory_valid;
    logic [PAYLOAD_W-1:0] request_memory_payload;
    logic                 done_out;

    // Scoreboard state
    logic [PAYLOAD_W-1:0] engine_expected [$];
    logic [PAYLOAD_W-1:0] memory_expected [$];
    logic [PAYLOAD_W-1:0] expected_word;
    int                   engine_received = 0;
    int                   memory_received = 0;
    time                  engine_last_time;
    time                  memory_last_time;
    time                  last_send_time;
    logic [31:0]          rng_state = 32'd66372;

    engine_pipeline UUT (.*);

    always #2 ap_clk = ~ap_clk;

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    // 32-bit xorshift on the shared state
    function automatic logic [31:0] random_word();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic lane_full(input bit memory_lane);
        return memory_lane ? response_memory_full : response_engine_full;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input logic [PAYLOAD_W-1:0] actual,
                               input logic [PAYLOAD_W-1:0] expected, input string what);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch at %0d ns: %s, got 0x%08h, expected 0x%08h",
                                     $time, what, actual, expected));
        end
    endtask

    // Sends one beat on a lane once that lane no longer reports full
    task automatic send_beat(input bit memory_lane, input logic [PAYLOAD_W-1:0] data);
        int cycles;
        cycles = 0;
        @(negedge ap_clk);
        while (lane_full(memory_lane)) begin
            if (cycles > WAIT_LIMIT) begin
                report_failure("timeout: the input FIFO stayed full");
            end
            cycles++;
            @(negedge ap_clk);
        end
        @(posedge ap_clk);
        last_send_time = $time;
        if (memory_lane) begin
            response_memory_valid   <= 1'b1;
            response_memory_payload <= data;
            memory_expected.push_back(data);
        end else begin
            response_engine_valid   <= 1'b1;
            response_engine_payload <= data;
            engine_expected.push_back(data);
        end
        @(posedge ap_clk);
        response_engine_valid <= 1'b0;
        response_memory_valid <= 1'b0;
    endtask

    task automatic wait_received(input int engine_count, input int memory_count);
        int cycles;
        cycles = 0;
        while (engine_received < engine_count || memory_received < memory_count) begin
            if (cycles > WAIT_LIMIT) begin
                report_failure("timeout: expected requests did not arrive");
            end
            cycles++;
            @(posedge ap_clk);
        end
    endtask

    task automatic wait_done_high();
        int cycles;
        cycles = 0;
        @(negedge ap_clk);
        while (done_out !== 1'b1) begin
            if (cycles > WAIT_LIMIT) begin
                report_failure("timeout: done_out never went high");
            end
            cycles++;
            @(negedge ap_clk);
        end
    endtask

    task automatic wait_engine_prog_full();
        int cycles;
        cycles = 0;
        @(negedge ap_clk);
        while (response_engine_prog_full !== 1'b1) begin
            if (cycles > WAIT_LIMIT) begin
                report_failure("timeout: response_engine_prog_full never went high");
            end
            cycles++;
            @(negedge ap_clk);
        end
    endtask

    // Request monitor on the falling edge
    always @(negedge ap_clk) begin
        if (request_engine_valid === 1'b1) begin
            if (engine_expected.size() == 0) begin
                report_failure("unexpected request on the engine lane");
            end else begin
                expected_word = engine_expected.pop_front();
                check_value(request_engine_payload, expected_word, "engine request payload");
                engine_received++;
                engine_last_time = $time;
            end
        end
        if (request_memory_valid === 1'b1) begin
            if (memory_expected.size() == 0) begin
                report_failure("unexpected request on the memory lane");
            end else begin
                expected_word = memory_expected.pop_front();
                check_value(request_memory_payload, expected_word, "memory request payload");
                memory_received++;
                memory_last_time = $time;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    task automatic test_reset_state();
        @(negedge ap_clk);
        check_value(PAYLOAD_W'(request_engine_valid), '0, "engine request valid after reset");
        check_value(PAYLOAD_W'(request_memory_valid), '0, "memory request valid after reset");
        check_value(PAYLOAD_W'(response_engine_full), '0, "engine full after reset");
        check_value(PAYLOAD_W'(response_memory_full), '0, "memory full after reset");
        check_value(PAYLOAD_W'(response_engine_prog_full), '0, "engine prog_full after reset");
        check_value(PAYLOAD_W'(response_memory_prog_full), '0, "memory prog_full after reset");
        wait_done_high();
    endtask

    task automatic test_single_packet();
        int eng_base;
        int mem_base;
        eng_base = engine_received;
        mem_base = memory_received;
        send_beat(1'b0, random_word());
        wait_received(eng_base + 1, mem_base);
        check_value(PAYLOAD_W'(engine_last_time - last_send_time >= MIN_DELAY), 1,
                    "engine latency of at least 8 cycles");
        send_beat(1'b1, random_word());
        wait_received(eng_base + 1, mem_base + 1);
        check_value(PAYLOAD_W'(memory_last_time - last_send_time >= MIN_DELAY), 1,
                    "memory latency of at least 8 cycles");
        // Quiet window where nothing more may come out
        repeat (20) @(posedge ap_clk);
        check_value(engine_received, eng_base + 1, "engine request count");
        check_value(memory_received, mem_base + 1, "memory request count");
    endtask

    // Both lanes at once with random gaps
    task automatic test_random_stream();
        int eng_base;
        int mem_base;
        int eng_sent;
        int mem_sent;
        int cycles;
        logic [31:0] coin;
        logic eng_full;
        logic mem_full;
        logic [PAYLOAD_W-1:0] data;
        eng_base = engine_received;
        mem_base = memory_received;
        eng_sent = 0;
        mem_sent = 0;
        cycles   = 0;
        while (eng_sent < 40 || mem_sent < 40) begin
            if (cycles > WAIT_LIMIT) begin
                report_failure("timeout: the random stream could not be sent");
            end
            cycles++;
            @(negedge ap_clk);
            eng_full = response_engine_full;
            mem_full = response_memory_full;
            coin     = random_word();
            @(posedge ap_clk);
            if (eng_sent < 40 && coin[0] && !eng_full) begin
                data = random_word();
                response_engine_valid   <= 1'b1;
                response_engine_payload <= data;
                engine_expected.push_back(data);
                eng_sent++;
            end else begin
                response_engine_valid <= 1'b0;
            end
            if (mem_sent < 40 && coin[1] && !mem_full) begin
                data = random_word();
                response_memory_valid   <= 1'b1;
                response_memory_payload <= data;
                memory_expected.push_back(data);
                mem_sent++;
            end else begin
                response_memory_valid <= 1'b0;
            end
        end
        @(posedge ap_clk);
        response_engine_valid <= 1'b0;
        response_memory_valid <= 1'b0;
        wait_received(eng_base + 40, mem_base + 40);
    endtask

    task automatic test_request_backpressure();
        int eng_base;
        eng_base = engine_received;
        @(posedge ap_clk);
        request_engine_pop_en <= 1'b0;
        repeat (12) send_beat(1'b0, random_word());
        wait_engine_prog_full();
        repeat (10) @(posedge ap_clk);
        check_value(engine_received, eng_base, "engine requests while pop enable is low");
        @(negedge ap_clk);
        check_value(PAYLOAD_W'(done_out), '0, "done_out with packets queued");
        @(posedge ap_clk);
        request_engine_pop_en <= 1'b1;
        wait_received(eng_base + 12, memory_received);
    endtask

    task automatic test_consumer_hold();
        int mem_base;
        mem_base = memory_received;
        @(posedge ap_clk);
        response_memory_pop_en <= 1'b0;
        repeat (6) send_beat(1'b1, random_word());
        repeat (20) @(posedge ap_clk);
        check_value(memory_received, mem_base, "memory requests while consumer is held");
        @(posedge ap_clk);
        response_memory_pop_en <= 1'b1;
        wait_received(engine_received, mem_base + 6);
    endtask

    task automatic test_done();
        int eng_base;
        int mem_base;
        eng_base = engine_received;
        mem_base = memory_received;
        @(posedge ap_clk);
        response_engine_pop_en <= 1'b0;
        response_memory_pop_en <= 1'b0;
        repeat (3) send_beat(1'b0, random_word());
        repeat (3) send_beat(1'b1, random_word());
        repeat (4) @(posedge ap_clk);
        @(negedge ap_clk);
        check_value(PAYLOAD_W'(done_out), '0, "done_out with packets in flight");
        @(posedge ap_clk);
        response_engine_pop_en <= 1'b1;
        response_memory_pop_en <= 1'b1;
        wait_received(eng_base + 3, mem_base + 3);
        wait_done_high();
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        areset_template_engine  <= 1'b1;
        response_engine_valid   <= 1'b0;
        response_engine_payload <= '0;
        response_engine_pop_en  <= 1'b1;
        request_engine_pop_en   <= 1'b1;
        response_memory_valid   <= 1'b0;
        response_memory_payload <= '0;
        response_memory_pop_en  <= 1'b1;
        request_memory_pop_en   <= 1'b1;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        areset_template_engine <= 1'b0;
        // Internal reset flop needs one more edge
        repeat (2) @(posedge ap_clk);

        test_reset_state();
        test_single_packet();
        test_random_stream();
        test_request_backpressure();
        test_consumer_hold();
        test_done();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule : tb_engine_pipeline

// ==== verilog.f ====
rtl/engine_pkg.sv
rtl/fifo_port_if.sv
rtl/packet_fifo.sv
rtl/hyper_pipeline.sv
rtl/engine_lane.sv
rtl/engine_pipeline.sv
verif/tb_engine_pipeline.sv

// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       = tb_engine_pipeline
FILELIST  = verilog.f

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
